/* src/riscv_pkg.sv */
// RV32I encoding constants and decoded operation types shared by the execute stage
`default_nettype none

package riscv_pkg;

    // Major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,                // Register-register ALU
        OPC_OP_IMM = 7'b0010011,                // Register-immediate ALU
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // ALU group funct3
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // Branch group funct3, overlaps the ALU codes
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    localparam logic [2:0] FUNCT3_JALR = 3'b000; // Only encoding defined for JALR

    // funct7 in instr[31:25]
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;
    localparam logic [6:0] FUNCT7_SRA  = 7'b0100000;

    // Operation selected by the decoder, one code per distinct ALU behaviour
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,                                // Signed compare
        ALU_BGE,
        ALU_BLTU,                               // Unsigned compare
        ALU_BGEU
    } alu_op_e;

    // What the write-back side does with the ALU result
    typedef enum logic [2:0] {
        KIND_ALU,                               // Includes LUI and AUIPC
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_ILLEGAL
    } instr_kind_e;

endpackage

`default_nettype wire

/* src/exec_if.sv */
// Decoded instruction bundle passed from the decoder to the ALU and write-back
`default_nettype none
`timescale 1ns/1ps

interface exec_if
    import riscv_pkg::*;
#(
    parameter int DWIDTH = 32,
    parameter int AWIDTH = 32
) ();

    logic              valid;
    alu_op_e           op;
    instr_kind_e       kind;
    logic [DWIDTH-1:0] op_a;                    // ALU operand A
    logic [DWIDTH-1:0] op_b;                    // ALU operand B
    logic [DWIDTH-1:0] rs1;                     // Raw register values
    logic [DWIDTH-1:0] rs2;
    logic [DWIDTH-1:0] imm;                     // Sign-extended immediate
    logic [AWIDTH-1:0] pc;
    logic [4:0]        rd;
    logic              rd_we;                   // Encoding carries a destination

    modport decode_mp (
        output valid, op, kind, op_a, op_b, rs1, rs2, imm, pc, rd, rd_we
    );

    modport alu_mp (
        input op, op_a, op_b, rs1, rs2
    );

    modport wb_mp (
        input valid, kind, imm, pc, rs1, rd, rd_we
    );

endinterface

`default_nettype wire

/* src/inst_decode.sv */
// Input register and RV32I decoder producing ALU operation, operands and kind
`default_nettype none
`timescale 1ns/1ps

module inst_decode
    import riscv_pkg::*;
#(
    parameter int DWIDTH = 32,
    parameter int AWIDTH = 32
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              valid_i,
    input  logic [DWIDTH-1:0] instr_i,
    input  logic [AWIDTH-1:0] pc_i,
    input  logic [DWIDTH-1:0] rs1_i,
    input  logic [DWIDTH-1:0] rs2_i,
    exec_if.decode_mp         dec
);

    opcode_e           opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [DWIDTH-1:0] imm_i_type;
    logic [DWIDTH-1:0] imm_u_type;
    logic [DWIDTH-1:0] imm_b_type;
    logic [DWIDTH-1:0] imm_j_type;
    logic [DWIDTH-1:0] pc_ext;
    alu_op_e           op_d;
    instr_kind_e       kind_d;
    logic [DWIDTH-1:0] op_a_d;
    logic [DWIDTH-1:0] op_b_d;
    logic [DWIDTH-1:0] imm_d;
    logic              rd_we_d;
    logic              bad_enc;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign pc_ext = DWIDTH'(pc_i);

    // Immediates by format, sign-extended to the data width
    assign imm_i_type = DWIDTH'($signed(instr_i[31:20]));
    assign imm_u_type = DWIDTH'($signed({instr_i[31:12], 12'b0}));
    assign imm_b_type = DWIDTH'($signed({instr_i[31], instr_i[7], instr_i[30:25],
                                         instr_i[11:8], 1'b0}));
    assign imm_j_type = DWIDTH'($signed({instr_i[31], instr_i[19:12], instr_i[20],
                                         instr_i[30:21], 1'b0}));

    // Shared by OP and OP_IMM, alt picks SUB or SRA
    function automatic alu_op_e alu_op_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            FUNCT3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL:     op = ALU_SLL;
            FUNCT3_SLT:     op = ALU_SLT;
            FUNCT3_SLTU:    op = ALU_SLTU;
            FUNCT3_XOR:     op = ALU_XOR;
            FUNCT3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:      op = ALU_OR;
            FUNCT3_AND:     op = ALU_AND;
            default:        op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        op_d    = ALU_ADD;
        kind_d  = KIND_ALU;
        op_a_d  = rs1_i;
        op_b_d  = rs2_i;
        imm_d   = '0;
        rd_we_d = 1'b1;
        bad_enc = 1'b0;
        case (opcode)
            OPC_OP: begin
                op_d    = alu_op_from_funct3(funct3, funct7 == FUNCT7_SUB);
                bad_enc = !(funct7 == FUNCT7_BASE ||
                            (funct7 == FUNCT7_SUB && (funct3 == FUNCT3_ADD_SUB ||
                                                      funct3 == FUNCT3_SRL_SRA)));
            end
            OPC_OP_IMM: begin
                imm_d  = imm_i_type;
                op_b_d = imm_i_type;
                op_d   = alu_op_from_funct3(funct3, funct3 == FUNCT3_SRL_SRA &&
                                                    funct7 == FUNCT7_SRA);
                if (funct3 == FUNCT3_SLL) begin
                    bad_enc = (funct7 != FUNCT7_BASE);
                end else if (funct3 == FUNCT3_SRL_SRA) begin
                    bad_enc = (funct7 != FUNCT7_BASE) && (funct7 != FUNCT7_SRA);
                end
            end
            OPC_LUI: begin
                imm_d  = imm_u_type;
                op_a_d = '0;                    // 0 + imm
                op_b_d = imm_u_type;
            end
            OPC_AUIPC: begin
                imm_d  = imm_u_type;
                op_a_d = pc_ext;
                op_b_d = imm_u_type;
            end
            OPC_JAL: begin
                kind_d = KIND_JAL;
                imm_d  = imm_j_type;
                op_a_d = pc_ext;                // Link value pc + 4
                op_b_d = DWIDTH'(4);
            end
            OPC_JALR: begin
                kind_d  = KIND_JALR;
                imm_d   = imm_i_type;
                op_a_d  = pc_ext;
                op_b_d  = DWIDTH'(4);
                bad_enc = (funct3 != FUNCT3_JALR);
            end
            OPC_BRANCH: begin
                kind_d  = KIND_BRANCH;
                imm_d   = imm_b_type;
                rd_we_d = 1'b0;                 // No rd field in B-type
                case (funct3)
                    FUNCT3_BEQ:  op_d = ALU_BEQ;
                    FUNCT3_BNE:  op_d = ALU_BNE;
                    FUNCT3_BLT:  op_d = ALU_BLT;
                    FUNCT3_BGE:  op_d = ALU_BGE;
                    FUNCT3_BLTU: op_d = ALU_BLTU;
                    FUNCT3_BGEU: op_d = ALU_BGEU;
                    default:     bad_enc = 1'b1;
                endcase
            end
            default: bad_enc = 1'b1;
        endcase
        if (bad_enc) begin
            kind_d = KIND_ILLEGAL;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= valid_i;
        end
    end

    // Payload only loads on a valid instruction
    always_ff @(posedge clk) begin
        if (valid_i) begin
            dec.op    <= op_d;
            dec.kind  <= kind_d;
            dec.op_a  <= op_a_d;
            dec.op_b  <= op_b_d;
            dec.rs1   <= rs1_i;
            dec.rs2   <= rs2_i;
            dec.imm   <= imm_d;
            dec.pc    <= pc_i;
            dec.rd    <= instr_i[11:7];
            dec.rd_we <= rd_we_d;
        end
    end

endmodule

`default_nettype wire

/* src/branch_control.sv */
// Branch comparator giving equality and signed or unsigned less-than of two registers
`default_nettype none
`timescale 1ns/1ps

module branch_control #(
    parameter int DWIDTH = 32
) (
    input  logic [DWIDTH-1:0] rs1_i,
    input  logic [DWIDTH-1:0] rs2_i,
    input  logic              unsigned_i,   // Set for BLTU and BGEU
    output logic              breq_o,
    output logic              brlt_o
);

    logic lt_signed;
    logic lt_unsigned;

    assign breq_o = (rs1_i == rs2_i);

    assign lt_unsigned = (rs1_i < rs2_i);

    // Sign bits differ: the negative one is smaller
    assign lt_signed = (rs1_i[DWIDTH-1] != rs2_i[DWIDTH-1]) ? rs1_i[DWIDTH-1]
                                                             : lt_unsigned;

    assign brlt_o = unsigned_i ? lt_unsigned : lt_signed;

endmodule

`default_nettype wire

/* src/alu.sv */
// Execute-stage ALU computing the result and the conditional branch decision
`default_nettype none
`timescale 1ns/1ps

module alu
    import riscv_pkg::*;
#(
    parameter int DWIDTH = 32
) (
    exec_if.alu_mp            ex,
    output logic [DWIDTH-1:0] res_o,
    output logic              brtaken_o
);

    localparam int SHW = (DWIDTH > 1) ? $clog2(DWIDTH) : 1;

    logic [SHW-1:0] shamt;
    logic           cmp_unsigned;
    logic           breq;
    logic           brlt;

    assign shamt        = ex.op_b[SHW-1:0];     // Low bits only, like RV32 shamt
    assign cmp_unsigned = (ex.op == ALU_BLTU) || (ex.op == ALU_BGEU);

    branch_control #(
        .DWIDTH (DWIDTH)
    ) br_ctrl (
        .rs1_i      (ex.rs1),
        .rs2_i      (ex.rs2),
        .unsigned_i (cmp_unsigned),
        .breq_o     (breq),
        .brlt_o     (brlt)
    );

    always_comb begin
        res_o     = '0;
        brtaken_o = 1'b0;
        case (ex.op)
            ALU_ADD: begin
                res_o = ex.op_a + ex.op_b;
            end
            ALU_SUB: begin
                res_o = ex.op_a - ex.op_b;
            end
            ALU_SLL: begin
                res_o = ex.op_a << shamt;
            end
            ALU_SLT: begin
                res_o = ($signed(ex.op_a) < $signed(ex.op_b)) ? DWIDTH'(1) : '0;
            end
            ALU_SLTU: begin
                res_o = (ex.op_a < ex.op_b) ? DWIDTH'(1) : '0;
            end
            ALU_XOR: begin
                res_o = ex.op_a ^ ex.op_b;
            end
            ALU_SRL: begin
                res_o = ex.op_a >> shamt;
            end
            ALU_SRA: begin
                res_o = $signed(ex.op_a) >>> shamt;   // Fills with the sign bit
            end
            ALU_OR: begin
                res_o = ex.op_a | ex.op_b;
            end
            ALU_AND: begin
                res_o = ex.op_a & ex.op_b;
            end
            // Branches leave the result at zero
            ALU_BEQ: begin
                brtaken_o = breq;
            end
            ALU_BNE: begin
                brtaken_o = ~breq;
            end
            ALU_BLT, ALU_BLTU: begin
                brtaken_o = brlt;
            end
            ALU_BGE, ALU_BGEU: begin
                brtaken_o = ~brlt;              // Not less-than
            end
            default: begin
                res_o     = '0;
                brtaken_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/exec_writeback.sv */
// Output register stage forming the redirect target and write-back controls
`default_nettype none
`timescale 1ns/1ps

module exec_writeback
    import riscv_pkg::*;
#(
    parameter int DWIDTH = 32,
    parameter int AWIDTH = 32
) (
    input  logic              clk,
    input  logic              reset_i,
    exec_if.wb_mp             ex,
    input  logic [DWIDTH-1:0] res_i,
    input  logic              brtaken_i,
    output logic              valid_o,
    output logic [DWIDTH-1:0] result_o,
    output logic [4:0]        rd_o,
    output logic              rd_we_o,
    output logic              redirect_o,
    output logic [AWIDTH-1:0] target_o,
    output logic              illegal_o
);

    logic [AWIDTH-1:0] jalr_base;
    logic [AWIDTH-1:0] target_d;
    logic              redirect_d;
    logic              wr_d;
    logic              illegal_d;

    assign jalr_base = AWIDTH'(ex.rs1 + ex.imm);

    always_comb begin
        case (ex.kind)
            KIND_BRANCH, KIND_JAL: target_d = ex.pc + AWIDTH'(ex.imm);
            KIND_JALR:             target_d = {jalr_base[AWIDTH-1:1], 1'b0};
            default:               target_d = '0;
        endcase
    end

    assign illegal_d  = (ex.kind == KIND_ILLEGAL);
    assign redirect_d = (ex.kind == KIND_BRANCH && brtaken_i) ||
                        (ex.kind == KIND_JAL) || (ex.kind == KIND_JALR);
    assign wr_d       = ex.rd_we && (ex.rd != 5'd0) && !illegal_d;   // x0 never written

    always_ff @(posedge clk) begin
        if (reset_i || !ex.valid) begin
            valid_o    <= 1'b0;
            result_o   <= '0;
            rd_o       <= '0;
            rd_we_o    <= 1'b0;
            redirect_o <= 1'b0;
            target_o   <= '0;
            illegal_o  <= 1'b0;
        end else begin
            valid_o    <= 1'b1;
            result_o   <= illegal_d ? '0 : res_i;
            rd_o       <= ex.rd;
            rd_we_o    <= wr_d;
            redirect_o <= redirect_d;
            target_o   <= target_d;
            illegal_o  <= illegal_d;
        end
    end

endmodule

`default_nettype wire

/* src/exec_stage.sv */
// RV32I execute stage top level joining decoder, ALU and write-back register
`default_nettype none
`timescale 1ns/1ps

module exec_stage #(
    parameter int DWIDTH = 32,
    parameter int AWIDTH = 32
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              valid_i,
    input  logic [DWIDTH-1:0] instr_i,
    input  logic [AWIDTH-1:0] pc_i,
    input  logic [DWIDTH-1:0] rs1_i,
    input  logic [DWIDTH-1:0] rs2_i,
    output logic              valid_o,
    output logic [DWIDTH-1:0] result_o,
    output logic [4:0]        rd_o,
    output logic              rd_we_o,
    output logic              redirect_o,
    output logic [AWIDTH-1:0] target_o,
    output logic              illegal_o
);

    logic [DWIDTH-1:0] alu_res;
    logic              alu_brtaken;

    exec_if #(
        .DWIDTH (DWIDTH),
        .AWIDTH (AWIDTH)
    ) exec_bus ();

    // First pipeline register
    inst_decode #(
        .DWIDTH (DWIDTH),
        .AWIDTH (AWIDTH)
    ) u_decode (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .instr_i (instr_i),
        .pc_i    (pc_i),
        .rs1_i   (rs1_i),
        .rs2_i   (rs2_i),
        .dec     (exec_bus)
    );

    alu #(
        .DWIDTH (DWIDTH)
    ) u_alu (
        .ex        (exec_bus),
        .res_o     (alu_res),
        .brtaken_o (alu_brtaken)
    );

    // Second pipeline register, drives the stage outputs
    exec_writeback #(
        .DWIDTH (DWIDTH),
        .AWIDTH (AWIDTH)
    ) u_writeback (
        .clk        (clk),
        .reset_i    (reset_i),
        .ex         (exec_bus),
        .res_i      (alu_res),
        .brtaken_i  (alu_brtaken),
        .valid_o    (valid_o),
        .result_o   (result_o),
        .rd_o       (rd_o),
        .rd_we_o    (rd_we_o),
        .redirect_o (redirect_o),
        .target_o   (target_o),
        .illegal_o  (illegal_o)
    );

endmodule

`default_nettype wire

/* tests/exec_stage_tb.sv */
// Self-checking testbench for the execute stage using file patterns and random R-type tests
`default_nettype none
`timescale 1ns/1ps

module exec_stage_tb
    import riscv_pkg::*;
();

    localparam int DWIDTH     = 32;
    localparam int AWIDTH     = 32;
    localparam int CLK_PERIOD = 4;
    localparam int NUM_PAT    = 37;                     // Lines in the pattern file
    localparam int NUM_RAND   = 64;
    localparam int NUM_TESTS  = NUM_PAT + NUM_RAND;

    typedef struct packed {
        logic [31:0]       num;
        logic [DWIDTH-1:0] result;
        logic [AWIDTH-1:0] target;
        logic [4:0]        rd;
        logic              check_rd;
        logic              redirect;
        logic              rd_we;
        logic              illegal;
        logic [31:0]       due;                         // Cycle count when valid_o is due
    } expect_t;

    logic              clk = 1'b0;
    logic              reset_i;
    logic              valid_i;
    logic [DWIDTH-1:0] instr_i;
    logic [AWIDTH-1:0] pc_i;
    logic [DWIDTH-1:0] rs1_i;
    logic [DWIDTH-1:0] rs2_i;
    logic              valid_o;
    logic [DWIDTH-1:0] result_o;
    logic [4:0]        rd_o;
    logic              rd_we_o;
    logic              redirect_o;
    logic [AWIDTH-1:0] target_o;
    logic              illegal_o;

    logic [31:0] pat_mem [0:NUM_PAT*7-1];
    expect_t     exp_q[$];
    expect_t     cur;
    int          cycle = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          other_errors = 0;
    bit          test_err;
    logic [31:0] seed;

    exec_stage #(
        .DWIDTH (DWIDTH),
        .AWIDTH (AWIDTH)
    ) UUT (
        .clk        (clk),
        .reset_i    (reset_i),
        .valid_i    (valid_i),
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .valid_o    (valid_o),
        .result_o   (result_o),
        .rd_o       (rd_o),
        .rd_we_o    (rd_we_o),
        .redirect_o (redirect_o),
        .target_o   (target_o),
        .illegal_o  (illegal_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // RV32I register-register semantics
    function automatic logic [31:0] r_type_model(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? (a - b) : (a + b);
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic check_result(input int num, input string name,
                                input logic [DWIDTH-1:0] expv, input logic [DWIDTH-1:0] actv);
        if (actv !== expv) begin
            $display("Mismatch at %0t: test %0d %s expected %h got %h",
                     $time, num, name, expv, actv);
            test_err = 1'b1;
        end
    endtask

    task automatic check_flag(input int num, input string name, input logic expv,
                              input logic actv);
        if (actv !== expv) begin
            $display("Mismatch at %0t: test %0d %s expected %b got %b",
                     $time, num, name, expv, actv);
            test_err = 1'b1;
        end
    endtask

    task automatic check_kind_flags(input int num, input logic exp_we, input logic exp_ill,
                                    input logic act_we, input logic act_ill);
        if (act_we !== exp_we || act_ill !== exp_ill) begin
            $display("Mismatch at %0t: test %0d rd_we/illegal expected %b/%b got %b/%b",
                     $time, num, exp_we, exp_ill, act_we, act_ill);
            test_err = 1'b1;
        end
    endtask

    task automatic check_output(input expect_t e);
        test_err = 1'b0;
        if (cycle != e.due) begin
            $display("Test %0d: output came at the wrong time, cycle %0d instead of %0d",
                     e.num, cycle, e.due);
            test_err = 1'b1;
        end
        check_result(e.num, "result", e.result, result_o);
        check_flag(e.num, "redirect", e.redirect, redirect_o);
        check_result(e.num, "target", e.target, target_o);
        check_kind_flags(e.num, e.rd_we, e.illegal, rd_we_o, illegal_o);
        if (e.check_rd) begin
            check_result(e.num, "rd", DWIDTH'(e.rd), DWIDTH'(rd_o));
        end
        if (test_err) begin
            fail_count++;
            $display("Test %0d failed", e.num);
        end else begin
            pass_count++;
            $display("Test %0d passed", e.num);
        end
    endtask

    // Drives one instruction per call so that calls in a row go back to back
    task automatic apply_instr(input logic [DWIDTH-1:0] instr, input logic [AWIDTH-1:0] pc,
                               input logic [DWIDTH-1:0] rs1, input logic [DWIDTH-1:0] rs2,
                               input expect_t e);
        expect_t rec;
        @(posedge clk);
        #1;
        valid_i = 1'b1;
        instr_i = instr;
        pc_i    = pc;
        rs1_i   = rs1;
        rs2_i   = rs2;
        rec     = e;
        rec.due = cycle + 2;                            // Decode and write-back registers
        exp_q.push_back(rec);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            valid_i = 1'b0;
        end
    endtask

    task automatic run_directed();
        expect_t e;
        int      base;
        for (int t = 0; t < NUM_PAT; t++) begin
            base       = t * 7;
            e          = '0;
            e.num      = t;
            e.result   = pat_mem[base+4];
            e.redirect = pat_mem[base+5][0];
            e.rd_we    = pat_mem[base+5][1];
            e.illegal  = pat_mem[base+5][2];
            e.target   = pat_mem[base+6];
            apply_instr(pat_mem[base], pat_mem[base+1], pat_mem[base+2], pat_mem[base+3], e);
        end
    endtask

    task automatic run_random();
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sel;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [31:0] instr;
        for (int t = 0; t < NUM_RAND; t++) begin
            seed = xorshift32(seed);
            a    = seed;
            seed = xorshift32(seed);
            b    = seed;
            seed = xorshift32(seed);
            sel  = seed;
            f3   = sel[2:0];
            alt  = sel[3] && (f3 == FUNCT3_ADD_SUB || f3 == FUNCT3_SRL_SRA);
            rd   = (t % 16 == 0) ? 5'd0 : sel[8:4];     // Some writes to x0
            instr = {alt ? FUNCT7_SUB : FUNCT7_BASE, 5'd2, 5'd1, f3, rd, OPC_OP};
            e          = '0;
            e.num      = NUM_PAT + t;
            e.result   = r_type_model(f3, alt, a, b);
            e.rd       = rd;
            e.check_rd = 1'b1;
            e.rd_we    = (rd != 5'd0);
            apply_instr(instr, AWIDTH'(32'h0000_4000 + t * 4), a, b, e);
        end
    endtask

    // Outputs are compared half a cycle after the edge that updates them
    always @(negedge clk) begin
        if (reset_i === 1'b1) begin
            if ({valid_o, rd_we_o, redirect_o, illegal_o} !== 4'b0000) begin
                $display("Control outputs were not low during reset at %0t", $time);
                other_errors++;
            end
        end else if (valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("valid_o rose at %0t with no instruction in flight", $time);
                other_errors++;
            end else begin
                cur = exp_q.pop_front();
                check_output(cur);
            end
        end else begin
            if ({valid_o, rd_we_o, redirect_o, illegal_o} !== 4'b0000) begin
                $display("Control outputs were high or unknown without valid_o at %0t", $time);
                other_errors++;
            end
            if (exp_q.size() != 0 && exp_q[0].due < cycle) begin
                cur = exp_q.pop_front();
                $display("Test %0d: output came at the wrong time, it never appeared", cur.num);
                fail_count++;
            end
        end
    end

    initial begin
        reset_i = 1'b1;
        valid_i = 1'b1;                                 // JAL x1 held in reset is dropped
        instr_i = 32'h1000_00EF;
        pc_i    = 32'h0000_1000;
        rs1_i   = '0;
        rs2_i   = '0;
        seed    = 32'd26009;
        $readmemh("tests/exec_patterns.txt", pat_mem);
        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;
        valid_i = 1'b0;
        if ($isunknown(pat_mem[NUM_PAT*7-1])) begin
            $display("The pattern file tests/exec_patterns.txt could not be read in full");
            other_errors++;
        end else begin
            run_directed();
            idle_cycles(2);                             // Bubble between the two groups
            run_random();
        end
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("Passed: %0d  Failed: %0d  Other errors: %0d",
                 pass_count, fail_count, other_errors);
        if (fail_count == 0 && other_errors == 0 && pass_count == NUM_TESTS) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #((NUM_TESTS + 20) * 4 * CLK_PERIOD);
        $display("Watchdog expired before all tests had finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/exec_patterns.txt */
// instr    pc       rs1      rs2      result   flags target
// flags: bit 0 redirect, bit 1 rd_we, bit 2 illegal
002081B3 00001000 00000005 00000007 0000000C 2 00000000 // add
402081B3 00001004 00000005 00000007 FFFFFFFE 2 00000000 // sub
002091B3 00001008 00000001 00000024 00000010 2 00000000 // sll, low shamt bits
0020A1B3 0000100C FFFFFFFF 00000001 00000001 2 00000000 // slt
0020B1B3 00001010 FFFFFFFF 00000001 00000000 2 00000000 // sltu
0020C1B3 00001014 0F0F0F0F 00FF00FF 0FF00FF0 2 00000000 // xor
0020D1B3 00001018 80000000 00000004 08000000 2 00000000 // srl
4020D1B3 0000101C 80000000 00000004 F8000000 2 00000000 // sra
0020E1B3 00001020 0F0F0000 0000F0F0 0F0FF0F0 2 00000000 // or
0020F1B3 00001024 FF00FF00 0FF00FF0 0F000F00 2 00000000 // and
FFF08193 00001028 00000010 00000000 0000000F 2 00000000 // addi -1
0050A193 0000102C FFFFFFF0 00000000 00000001 2 00000000 // slti
0050B193 00001030 FFFFFFF0 00000000 00000000 2 00000000 // sltiu
4080D193 00001034 80000000 00000000 FF800000 2 00000000 // srai 8
0080D193 00001038 80000000 00000000 00800000 2 00000000 // srli 8
0FF0F193 0000103C 12345678 00000000 00000078 2 00000000 // andi
00208033 00001040 00000001 00000002 00000003 0 00000000 // add into x0
123451B7 00001044 00000000 00000000 12345000 2 00000000 // lui
00001197 00002000 00000000 00000000 00003000 2 00000000 // auipc
100000EF 00001000 00000000 00000000 00001004 3 00001100 // jal x1 +256
FFDFF06F 00001010 00000000 00000000 00001014 1 0000100C // jal x0 -4
004280E7 00002000 00003001 00000000 00002004 3 00003004 // jalr, bit 0 cleared
FFF28067 00002100 00004000 00000000 00002104 1 00003FFE // jalr x0 -1
00208863 00003000 00000005 00000005 00000000 1 00003010 // beq taken
FE208CE3 00003000 00000005 00000006 00000000 0 00002FF8 // beq not taken
00209863 00003000 00000005 00000006 00000000 1 00003010 // bne taken
00209863 00003000 00000007 00000007 00000000 0 00003010 // bne not taken
0020C863 00003000 FFFFFFFF 00000001 00000000 1 00003010 // blt taken
FE20CCE3 00003000 00000001 FFFFFFFF 00000000 0 00002FF8 // blt not taken
0020D863 00003000 00000001 FFFFFFFF 00000000 1 00003010 // bge taken
0020D863 00003000 80000000 00000000 00000000 0 00003010 // bge not taken
0020E863 00003000 FFFFFFFF 00000001 00000000 0 00003010 // bltu not taken
FE20ECE3 00003000 00000001 FFFFFFFF 00000000 1 00002FF8 // bltu taken
0020F863 00003000 FFFFFFFF 00000001 00000000 1 00003010 // bgeu taken
0020F863 00003000 00000003 00000004 00000000 0 00003010 // bgeu not taken
0000A183 00003004 00000001 00000002 00000000 4 00000000 // load opcode
022081B3 00003008 00000003 00000004 00000000 4 00000000 // funct7 01

/* verilog.f */
src/riscv_pkg.sv
src/exec_if.sv
src/inst_decode.sv
src/branch_control.sv
src/alu.sv
src/exec_writeback.sv
src/exec_stage.sv
tests/exec_stage_tb.sv
